// ==== verilog/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

    // Clock cycles spent on each pixel slot
    localparam int unsigned phase_count = 16;
    localparam int unsigned phase_w = 4;

    // Panel is driven at 6 bits per channel
    localparam int unsigned color_w = 6;
    localparam logic [color_w-1:0] color_max = '1;

    // Counter widths cover the default 507 x 112 total geometry
    localparam int unsigned x_w = 9;
    localparam int unsigned y_w = 7;

    typedef enum logic [1:0] {
        PAT_OFF  = 2'd0, // All black
        PAT_BOX  = 2'd1, // White rectangle on black
        PAT_BARS = 2'd2, // Eight colour bars of 8 columns each
        PAT_GRAD = 2'd3  // Red follows column and green follows row
    } pattern_mode_e;

endpackage

`default_nettype wire

// ==== verilog/lcd_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_timing #(
    parameter int unsigned h_active = 400,
    parameter int unsigned h_total  = 507,
    parameter int unsigned v_active = 96,
    parameter int unsigned v_total  = 112
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    output logic      [lcd_pkg::x_w-1:0]      x_o,
    output logic      [lcd_pkg::y_w-1:0]      y_o,
    output logic                              active_o,
    output logic                              hsync_o,
    output logic                              vsync_o,
    output logic                              pop_o,
    output logic                              latch_o,
    output logic      [lcd_pkg::phase_w-1:0]  phase_o
);

    import lcd_pkg::*;

    // Strobes are registered, so each decode looks one phase ahead
    localparam logic [phase_w-1:0] ph_last   = phase_w'(phase_count - 1);
    localparam logic [phase_w-1:0] ph_pop    = phase_w'(phase_count - 1);
    localparam logic [phase_w-1:0] ph_latch  = phase_w'(phase_count - 2);
    localparam logic [phase_w-1:0] ph_step_y = phase_w'(phase_count - 3);
    localparam logic [phase_w-1:0] ph_step_x = phase_w'(phase_count - 4);

    localparam logic [x_w-1:0] x_last = x_w'(h_total - 1);
    localparam logic [x_w-1:0] x_act  = x_w'(h_active);
    localparam logic [y_w-1:0] y_last = y_w'(v_total - 1);
    localparam logic [y_w-1:0] y_act  = y_w'(v_active);

    logic [phase_w-1:0] phase_q;
    logic               step_x_q;
    logic               step_y_q;
    logic               latch_q;
    logic               pop_q;
    logic [x_w-1:0]     x_q;
    logic [y_w-1:0]     y_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= '0;
        end else if (phase_q == ph_last) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step_x_q <= 1'b0;
            step_y_q <= 1'b0;
            latch_q  <= 1'b0;
            pop_q    <= 1'b0;
        end else begin
            step_x_q <= (phase_q == ph_step_x);
            step_y_q <= (phase_q == ph_step_y);
            latch_q  <= (phase_q == ph_latch);
            pop_q    <= (phase_q == ph_pop);
        end
    end

    // Start in blanking so the first frame is not a partial one
    always_ff @(posedge clk) begin
        if (rst) begin
            x_q <= x_act;
        end else if (step_x_q) begin
            x_q <= (x_q == x_last) ? '0 : x_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            y_q <= y_act;
        end else if (step_y_q && x_q == '0) begin // Column wrapped one cycle earlier
            y_q <= (y_q == y_last) ? '0 : y_q + 1'b1;
        end
    end

    assign x_o      = x_q;
    assign y_o      = y_q;
    assign active_o = (x_q < x_act) && (y_q < y_act);
    assign hsync_o  = (x_q == x_act);
    assign vsync_o  = (y_q == y_act);
    assign pop_o    = pop_q;
    assign latch_o  = latch_q;
    assign phase_o  = phase_q;

    a_pop_latch_apart: assert property (@(posedge clk) disable iff (rst)
        !(pop_q && latch_q));

    a_pos_in_frame: assert property (@(posedge clk) disable iff (rst)
        (x_q <= x_last) && (y_q <= y_last));

endmodule

`default_nettype wire

// ==== verilog/pattern_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module pattern_gen #(
    parameter int unsigned box_x0 = 20,
    parameter int unsigned box_x1 = 30,
    parameter int unsigned box_y0 = 10,
    parameter int unsigned box_y1 = 30
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic   [lcd_pkg::x_w-1:0]      x_i,
    input  wire logic   [lcd_pkg::y_w-1:0]      y_i,
    input  wire logic                           pop_i,
    input  wire lcd_pkg::pattern_mode_e         mode_i,
    output logic        [lcd_pkg::color_w-1:0]  r_o,
    output logic        [lcd_pkg::color_w-1:0]  g_o,
    output logic        [lcd_pkg::color_w-1:0]  b_o,
    output logic                                ack_o
);

    import lcd_pkg::*;

    localparam logic [x_w-1:0] bx0 = x_w'(box_x0);
    localparam logic [x_w-1:0] bx1 = x_w'(box_x1);
    localparam logic [y_w-1:0] by0 = y_w'(box_y0);
    localparam logic [y_w-1:0] by1 = y_w'(box_y1);

    logic               in_box;
    logic [2:0]         bar_idx;
    logic [color_w-1:0] r_d;
    logic [color_w-1:0] g_d;
    logic [color_w-1:0] b_d;
    logic [color_w-1:0] r_q;
    logic [color_w-1:0] g_q;
    logic [color_w-1:0] b_q;
    logic               ack_q;

    // Box edges are exclusive on the low side, inclusive on the high side
    assign in_box  = (x_i > bx0) && (x_i <= bx1) && (y_i > by0) && (y_i <= by1);
    assign bar_idx = x_i[5:3];

    always_comb begin
        r_d = '0;
        g_d = '0;
        b_d = '0;
        case (mode_i)
            PAT_BOX: begin
                if (in_box) begin
                    r_d = color_max;
                    g_d = color_max;
                    b_d = color_max;
                end
            end
            PAT_BARS: begin
                r_d = bar_idx[2] ? color_max : '0;
                g_d = bar_idx[1] ? color_max : '0;
                b_d = bar_idx[0] ? color_max : '0;
            end
            PAT_GRAD: begin
                r_d = x_i[color_w-1:0]; // Wraps every 64 columns
                g_d = y_i[color_w-1:0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (pop_i) begin
            r_q <= r_d;
            g_q <= g_d;
            b_q <= b_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= pop_i;
        end
    end

    assign r_o   = r_q;
    assign g_o   = g_q;
    assign b_o   = b_q;
    assign ack_o = ack_q;

    a_ack_follows_pop: assert property (@(posedge clk) disable iff (rst)
        pop_i |=> ack_o ##1 !ack_o);

endmodule

`default_nettype wire

// ==== verilog/lcd_pixel_out.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_pixel_out (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           pop_i,
    input  wire logic                           ack_i,
    input  wire logic                           latch_i,
    input  wire logic   [lcd_pkg::phase_w-1:0]  phase_i,
    input  wire logic                           active_i,
    input  wire logic                           hsync_i,
    input  wire logic                           vsync_i,
    input  wire logic   [lcd_pkg::color_w-1:0]  r_i,
    input  wire logic   [lcd_pkg::color_w-1:0]  g_i,
    input  wire logic   [lcd_pkg::color_w-1:0]  b_i,
    output logic        [lcd_pkg::color_w-1:0]  lcd_r_o,
    output logic        [lcd_pkg::color_w-1:0]  lcd_g_o,
    output logic        [lcd_pkg::color_w-1:0]  lcd_b_o,
    output logic                                lcd_hsync_o,
    output logic                                lcd_vsync_o,
    output logic                                lcd_de_o,
    output logic                                lcd_nclk_o
);

    import lcd_pkg::*;

    logic               req_q;
    logic               pend_active_q;
    logic               pend_hsync_q;
    logic               pend_vsync_q;
    logic [color_w-1:0] pend_r_q;
    logic [color_w-1:0] pend_g_q;
    logic [color_w-1:0] pend_b_q;
    logic [phase_w-1:0] phase_next;

    // Request stays outstanding from pop until its ack
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
        end else if (pop_i) begin
            req_q <= 1'b1;
        end else if (ack_i) begin
            req_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_active_q <= 1'b0;
            pend_hsync_q  <= 1'b0;
            pend_vsync_q  <= 1'b0;
            pend_r_q      <= '0;
            pend_g_q      <= '0;
            pend_b_q      <= '0;
        end else begin
            if (pop_i) begin
                pend_active_q <= active_i;
                pend_hsync_q  <= hsync_i;
                pend_vsync_q  <= vsync_i;
            end
            if (ack_i) begin
                pend_r_q <= pend_active_q ? r_i : '0; // Blanking is always black
                pend_g_q <= pend_active_q ? g_i : '0;
                pend_b_q <= pend_active_q ? b_i : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lcd_r_o     <= '0;
            lcd_g_o     <= '0;
            lcd_b_o     <= '0;
            lcd_hsync_o <= 1'b1;
            lcd_vsync_o <= 1'b1;
            lcd_de_o    <= 1'b0;
        end else if (latch_i) begin
            lcd_r_o     <= pend_r_q;
            lcd_g_o     <= pend_g_q;
            lcd_b_o     <= pend_b_q;
            lcd_hsync_o <= !pend_hsync_q; // Panel syncs are active low
            lcd_vsync_o <= !pend_vsync_q;
            lcd_de_o    <= pend_active_q;
        end
    end

    // Registered from the following phase so it rises with the pins
    assign phase_next = phase_i + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            lcd_nclk_o <= 1'b0;
        end else begin
            lcd_nclk_o <= !phase_next[phase_w-1];
        end
    end

    a_ack_has_req: assert property (@(posedge clk) disable iff (rst)
        ack_i |-> req_q);

endmodule

`default_nettype wire

// ==== verilog/lcd_panel_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_panel_top #(
    parameter int unsigned h_active = 400,
    parameter int unsigned h_total  = 507,
    parameter int unsigned v_active = 96,
    parameter int unsigned v_total  = 112,
    parameter int unsigned box_x0   = 20,
    parameter int unsigned box_x1   = 30,
    parameter int unsigned box_y0   = 10,
    parameter int unsigned box_y1   = 30
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire lcd_pkg::pattern_mode_e         mode_i,
    output logic        [lcd_pkg::color_w-1:0]  lcd_r_o,
    output logic        [lcd_pkg::color_w-1:0]  lcd_g_o,
    output logic        [lcd_pkg::color_w-1:0]  lcd_b_o,
    output logic                                lcd_hsync_o,
    output logic                                lcd_vsync_o,
    output logic                                lcd_de_o,
    output logic                                lcd_nclk_o
);

    import lcd_pkg::*;

    logic [x_w-1:0]     x;
    logic [y_w-1:0]     y;
    logic               active;
    logic               hsync;
    logic               vsync;
    logic               pop;
    logic               latch;
    logic [phase_w-1:0] phase;
    logic [color_w-1:0] r;
    logic [color_w-1:0] g;
    logic [color_w-1:0] b;
    logic               ack;

    lcd_timing #(
        .h_active (h_active),
        .h_total  (h_total),
        .v_active (v_active),
        .v_total  (v_total)
    ) i_timing (
        .clk      (clk),
        .rst      (rst),
        .x_o      (x),
        .y_o      (y),
        .active_o (active),
        .hsync_o  (hsync),
        .vsync_o  (vsync),
        .pop_o    (pop),
        .latch_o  (latch),
        .phase_o  (phase)
    );

    pattern_gen #(
        .box_x0 (box_x0),
        .box_x1 (box_x1),
        .box_y0 (box_y0),
        .box_y1 (box_y1)
    ) i_pattern (
        .clk    (clk),
        .rst    (rst),
        .x_i    (x),
        .y_i    (y),
        .pop_i  (pop),
        .mode_i (mode_i),
        .r_o    (r),
        .g_o    (g),
        .b_o    (b),
        .ack_o  (ack)
    );

    lcd_pixel_out i_pixel_out (
        .clk         (clk),
        .rst         (rst),
        .pop_i       (pop),
        .ack_i       (ack),
        .latch_i     (latch),
        .phase_i     (phase),
        .active_i    (active),
        .hsync_i     (hsync),
        .vsync_i     (vsync),
        .r_i         (r),
        .g_i         (g),
        .b_i         (b),
        .lcd_r_o     (lcd_r_o),
        .lcd_g_o     (lcd_g_o),
        .lcd_b_o     (lcd_b_o),
        .lcd_hsync_o (lcd_hsync_o),
        .lcd_vsync_o (lcd_vsync_o),
        .lcd_de_o    (lcd_de_o),
        .lcd_nclk_o  (lcd_nclk_o)
    );

endmodule

`default_nettype wire

// ==== verif/tb_lcd_panel.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_lcd_panel;

    import lcd_pkg::*;

    localparam int h_active     = 24;
    localparam int h_total      = 30;
    localparam int v_active     = 12;
    localparam int v_total      = 16;
    localparam int box_x0       = 4;
    localparam int box_x1       = 12;
    localparam int box_y0       = 2;
    localparam int box_y1       = 8;
    localparam int clk_period   = 4;
    localparam int frame_slots  = h_total * v_total;
    localparam int frame_cycles = frame_slots * int'(phase_count);
    localparam int full_scale   = (1 << color_w) - 1;
    localparam int pins_w       = 3 * int'(color_w) + 3;
    localparam int n_tests      = 5;

    // Each row is applied during a vsync row, one frame is discarded, then frames are checked
    string         test_name   [n_tests] = '{"box", "bars", "gradient", "off", "box_again"};
    pattern_mode_e test_mode   [n_tests] = '{PAT_BOX, PAT_BARS, PAT_GRAD, PAT_OFF, PAT_BOX};
    int            test_frames [n_tests] = '{2, 1, 1, 1, 1};

    logic               clk;
    logic               rst;
    pattern_mode_e      mode;
    logic [color_w-1:0] lcd_r;
    logic [color_w-1:0] lcd_g;
    logic [color_w-1:0] lcd_b;
    logic               lcd_hsync;
    logic               lcd_vsync;
    logic               lcd_de;
    logic               lcd_nclk;

    int                 errors;
    int                 checks;
    string              cur_name;
    pattern_mode_e      cur_mode;
    logic               pixel_check_en;
    logic               aligned;
    int                 pos_x;
    int                 pos_y;
    logic               prev_nclk;
    logic               prev_vsync;
    logic [pins_w-1:0]  prev_pins;
    int                 run_len;
    int                 edges_seen;
    logic               slot_done;
    logic               vsync_rose;

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    lcd_panel_top #(
        .h_active (h_active),
        .h_total  (h_total),
        .v_active (v_active),
        .v_total  (v_total),
        .box_x0   (box_x0),
        .box_x1   (box_x1),
        .box_y0   (box_y0),
        .box_y1   (box_y1)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .mode_i      (mode),
        .lcd_r_o     (lcd_r),
        .lcd_g_o     (lcd_g),
        .lcd_b_o     (lcd_b),
        .lcd_hsync_o (lcd_hsync),
        .lcd_vsync_o (lcd_vsync),
        .lcd_de_o    (lcd_de),
        .lcd_nclk_o  (lcd_nclk)
    );

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d at x %0d y %0d, time %0t",
                     name, expected, actual, pos_x, pos_y, $time);
        end
    endtask

    function automatic int table_frames();
        int total;
        total = 0;
        for (int t = 0; t < n_tests; t++)
            total += test_frames[t] + 2; // Wait for vsync and the discarded frame
        return total;
    endfunction

    function automatic logic [pins_w-1:0] pins_now();
        return {lcd_r, lcd_g, lcd_b, lcd_hsync, lcd_vsync, lcd_de};
    endfunction

    task automatic model_pixel(input pattern_mode_e m, input int x, input int y,
                               output int r, output int g, output int b);
        int bar;
        r = 0;
        g = 0;
        b = 0;
        bar = (x / 8) % 8;
        case (m)
            PAT_BOX: begin
                if (x > box_x0 && x <= box_x1 && y > box_y0 && y <= box_y1) begin
                    r = full_scale;
                    g = full_scale;
                    b = full_scale;
                end
            end
            PAT_BARS: begin
                r = ((bar & 4) != 0) ? full_scale : 0;
                g = ((bar & 2) != 0) ? full_scale : 0;
                b = ((bar & 1) != 0) ? full_scale : 0;
            end
            PAT_GRAD: begin
                r = x % (1 << color_w);
                g = y % (1 << color_w);
            end
            default: ;
        endcase
    endtask

    task automatic check_slot();
        int exp_r;
        int exp_g;
        int exp_b;
        int exp_de;
        exp_r = 0;
        exp_g = 0;
        exp_b = 0;
        exp_de = (pos_x < h_active && pos_y < v_active) ? 1 : 0;
        check_value({cur_name, " hsync"}, (pos_x == h_active) ? 0 : 1, int'(lcd_hsync));
        check_value({cur_name, " vsync"}, (pos_y == v_active) ? 0 : 1, int'(lcd_vsync));
        check_value({cur_name, " de"}, exp_de, int'(lcd_de));
        if (exp_de == 0 || pixel_check_en) begin
            if (exp_de == 1)
                model_pixel(cur_mode, pos_x, pos_y, exp_r, exp_g, exp_b);
            check_value({cur_name, " red"}, exp_r, int'(lcd_r));
            check_value({cur_name, " green"}, exp_g, int'(lcd_g));
            check_value({cur_name, " blue"}, exp_b, int'(lcd_b));
        end
    endtask

    // All pins are sampled mid-cycle, away from the rising clock edge
    task automatic step_cycle();
        logic [pins_w-1:0] pins;
        logic              nclk_rise;
        logic              nclk_fall;
        @(negedge clk);
        pins = pins_now();
        nclk_rise = !prev_nclk && lcd_nclk;
        nclk_fall = prev_nclk && !lcd_nclk;
        vsync_rose = !prev_vsync && lcd_vsync;
        slot_done = 1'b0;
        if (pins != prev_pins && !nclk_rise) begin
            errors++;
            $display("Panel pins changed at %0t while the pixel clock did not rise", $time);
        end
        if (nclk_rise || nclk_fall) begin
            if (edges_seen >= 2) // The first high phase after reset is short
                check_value("pixel clock half period", 8, run_len);
            edges_seen++;
            run_len = 1;
        end else begin
            run_len++;
        end
        if (nclk_rise && aligned) begin
            if (pos_x == h_total - 1) begin
                pos_x = 0;
                pos_y = (pos_y == v_total - 1) ? 0 : pos_y + 1;
            end else begin
                pos_x++;
            end
        end else if (nclk_rise && vsync_rose) begin
            aligned = 1'b1; // First slot after the vsync row
            pos_x = 0;
            pos_y = v_active + 1;
        end
        if (nclk_fall && aligned) begin
            check_slot();
            slot_done = 1'b1;
        end
        prev_pins = pins;
        prev_nclk = lcd_nclk;
        prev_vsync = lcd_vsync;
    endtask

    task automatic wait_vsync_low();
        do step_cycle();
        while (lcd_vsync != 1'b0);
    endtask

    task automatic wait_vsync_rise();
        do step_cycle();
        while (!vsync_rose);
    endtask

    task automatic run_slots(input int n);
        int done;
        done = 0;
        while (done < n) begin
            step_cycle();
            if (slot_done)
                done++;
        end
    endtask

    initial begin : watchdog
        int limit_cycles;
        limit_cycles = (table_frames() + 2) * frame_cycles;
        #(limit_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        errors = 0;
        checks = 0;
        cur_name = "reset";
        cur_mode = PAT_OFF;
        pixel_check_en = 1'b0;
        aligned = 1'b0;
        pos_x = 0;
        pos_y = 0;
        run_len = 0;
        edges_seen = 0;
        slot_done = 1'b0;
        vsync_rose = 1'b0;
        rst = 1'b1;
        mode = PAT_OFF;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("reset de", 0, int'(lcd_de));
        check_value("reset colour", 0, int'({lcd_r, lcd_g, lcd_b}));
        check_value("reset hsync", 1, int'(lcd_hsync));
        check_value("reset vsync", 1, int'(lcd_vsync));
        check_value("reset nclk", 0, int'(lcd_nclk));
        prev_pins = pins_now();
        prev_nclk = lcd_nclk;
        prev_vsync = lcd_vsync;
        rst = 1'b0;
        for (int t = 0; t < n_tests; t++) begin
            wait_vsync_low();
            mode = test_mode[t]; // Only blanking slots are requested until row 0
            cur_name = test_name[t];
            cur_mode = test_mode[t];
            pixel_check_en = 1'b0;
            wait_vsync_rise();
            run_slots(frame_slots);
            pixel_check_en = 1'b1;
            run_slots(test_frames[t] * frame_slots);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lcd_panel.f ====
verilog/lcd_pkg.sv
verilog/lcd_timing.sv
verilog/pattern_gen.sv
verilog/lcd_pixel_out.sv
verilog/lcd_panel_top.sv
verif/tb_lcd_panel.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f lcd_panel.f \
    --top-module tb_lcd_panel \
    -o sim

./obj_dir/sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0
